// File: common/rv_params.svh
/*
  RV32I core parameters
  Word and register index widths, the reset PC, the data memory depth
  and the instruction word that fills a killed pipeline slot.
*/
`ifndef RvParamsSvh
`define RvParamsSvh

// word width of the datapath
`define XLEN 32

// register index width for 32 registers
`define RegIdWidth 5

// first fetch address after reset
`define PcRst 32'h0000_0000

// data memory depth in words, 1 KiB
`define DmemWords 256

// addi x0, x0, 0
`define Nop 32'h0000_0013

`endif

// File: common/rvPkg.sv
/*
  rvPkg
  Encodings shared by the pipeline stages: RV32I major opcodes,
  ALU operations, branch kinds and load/store access widths.
*/
package rvPkg;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opImm    = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opReg    = 7'b0110011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111,
    opSystem = 7'b1110011
  } opcodeT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
    aluSrl, aluSra, aluOr, aluAnd,
    // lui result is the immediate itself
    aluPassB
  } aluOpT;

  typedef enum logic [3:0] {
    brNone, brEq, brNe, brLt, brGe, brLtu, brGeu, brJal, brJalr
  } brOpT;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    wdtByte = 2'd0,
    wdtHalf = 2'd1,
    wdtWord = 2'd2
  } memWdtT;

endpackage

// File: src/fetchUnit.sv
/*
  fetchUnit
  Program counter and the fetch/decode pipeline register. A redirect
  from execute loads the new target and turns the slot into a bubble;
  everything freezes once the core has halted.
*/
`include "rv_params.svh"

module fetchUnit (
  input  logic             clk,
  input  logic             arstN,
  input  logic [`XLEN-1:0] inst,
  input  logic             redirect,
  input  logic [`XLEN-1:0] redirectPc,
  input  logic             halt,
  output logic [`XLEN-1:0] pc,
  output logic [`XLEN-1:0] idPc,
  output logic [`XLEN-1:0] idInst,
  output logic             idValid
);

  logic [`XLEN-1:0] nextPc;

  assign nextPc = redirect ? redirectPc : pc + `XLEN'(4);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc      <= `PcRst;
      idValid <= 1'b0;
      idInst  <= `Nop;
    end else if (!halt) begin
      pc      <= nextPc;
      // the word fetched this cycle is on the wrong path
      idValid <= ~redirect;
      idInst  <= redirect ? `Nop : inst;
    end
  end

  always_ff @(posedge clk) begin
    if (!halt) begin
      idPc <= pc;
    end
  end

endmodule

// File: decode/decodeUnit.sv
/*
  decodeUnit
  Splits one RV32I instruction into register indexes, an immediate
  and the control flags used by execute and memory. Unknown encodings
  are flagged illegal and lose every side effect.
*/
`include "rv_params.svh"

module decodeUnit (
  input  logic [`XLEN-1:0]       idInst,
  input  logic                   idValid,
  input  logic [`XLEN-1:0]       idPc,
  input  logic [`XLEN-1:0]       rdata1,
  input  logic [`XLEN-1:0]       rdata2,
  output logic [`RegIdWidth-1:0] rs1,
  output logic [`RegIdWidth-1:0] rs2,
  output logic [`RegIdWidth-1:0] rd,
  output logic [`XLEN-1:0]       imm,
  output rvPkg::aluOpT           aluOp,
  output rvPkg::brOpT            brOp,
  output rvPkg::memWdtT          memWdt,
  output logic                   loadEn,
  output logic                   storeEn,
  output logic                   unsignedLd,
  output logic                   useImm,
  output logic                   usePc,
  output logic                   regWen,
  output logic                   isHalt,
  output logic                   isIllegal,
  output logic [`XLEN-1:0]       opA,
  output logic [`XLEN-1:0]       opB,
  output logic [`XLEN-1:0]       exPcOut,
  output logic                   exValidOut
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;

  // alt selects sub / sra
  function automatic rvPkg::aluOpT aluFor(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  aluFor = alt ? rvPkg::aluSub : rvPkg::aluAdd;
      3'b001:  aluFor = rvPkg::aluSll;
      3'b010:  aluFor = rvPkg::aluSlt;
      3'b011:  aluFor = rvPkg::aluSltu;
      3'b100:  aluFor = rvPkg::aluXor;
      3'b101:  aluFor = alt ? rvPkg::aluSra : rvPkg::aluSrl;
      3'b110:  aluFor = rvPkg::aluOr;
      default: aluFor = rvPkg::aluAnd;
    endcase
  endfunction

  assign funct3     = idInst[14:12];
  assign funct7     = idInst[31:25];
  assign rs1        = idInst[19:15];
  assign rs2        = idInst[24:20];
  assign rd         = idInst[11:7];
  assign opA        = rdata1;
  assign opB        = rdata2;
  assign exPcOut    = idPc;
  assign exValidOut = idValid;

  always_comb begin
    // I-type immediate unless the format says otherwise
    imm        = {{20{idInst[31]}}, idInst[31:20]};
    aluOp      = rvPkg::aluAdd;
    brOp       = rvPkg::brNone;
    memWdt     = rvPkg::memWdtT'(funct3[1:0]);
    unsignedLd = funct3[2];
    loadEn     = 1'b0;
    storeEn    = 1'b0;
    useImm     = 1'b0;
    usePc      = 1'b0;
    regWen     = 1'b0;
    isHalt     = 1'b0;
    legal      = 1'b1;
    case (rvPkg::opcodeT'(idInst[6:0]))
      rvPkg::opLui: begin
        imm    = {idInst[31:12], 12'b0};
        aluOp  = rvPkg::aluPassB;
        useImm = 1'b1;
        regWen = 1'b1;
      end
      rvPkg::opAuipc: begin
        imm    = {idInst[31:12], 12'b0};
        usePc  = 1'b1;
        useImm = 1'b1;
        regWen = 1'b1;
      end
      rvPkg::opJal: begin
        imm    = {{11{idInst[31]}}, idInst[31], idInst[19:12], idInst[20],
                  idInst[30:21], 1'b0};
        brOp   = rvPkg::brJal;
        regWen = 1'b1;
      end
      rvPkg::opJalr: begin
        brOp   = rvPkg::brJalr;
        regWen = 1'b1;
        legal  = funct3 == 3'b000;
      end
      rvPkg::opBranch: begin
        imm   = {{19{idInst[31]}}, idInst[31], idInst[7], idInst[30:25],
                 idInst[11:8], 1'b0};
        legal = funct3[2:1] != 2'b01;
        case (funct3)
          3'b000:  brOp = rvPkg::brEq;
          3'b001:  brOp = rvPkg::brNe;
          3'b100:  brOp = rvPkg::brLt;
          3'b101:  brOp = rvPkg::brGe;
          3'b110:  brOp = rvPkg::brLtu;
          default: brOp = rvPkg::brGeu;
        endcase
      end
      rvPkg::opLoad: begin
        loadEn = 1'b1;
        useImm = 1'b1;
        regWen = 1'b1;
        legal  = funct3[1:0] != 2'b11 && funct3 != 3'b110;
      end
      rvPkg::opStore: begin
        imm     = {{20{idInst[31]}}, idInst[31:25], idInst[11:7]};
        storeEn = 1'b1;
        useImm  = 1'b1;
        legal   = !funct3[2] && funct3[1:0] != 2'b11;
      end
      rvPkg::opImm: begin
        // bit 30 is part of the immediate except for shifts
        aluOp  = aluFor(funct3, funct3 == 3'b101 && idInst[30]);
        useImm = 1'b1;
        regWen = 1'b1;
        if (funct3 == 3'b001) begin
          legal = funct7 == 7'b0;
        end else if (funct3 == 3'b101) begin
          legal = funct7 == 7'b0 || funct7 == 7'b0100000;
        end
      end
      rvPkg::opReg: begin
        aluOp  = aluFor(funct3, idInst[30]);
        regWen = 1'b1;
        legal  = funct7 == 7'b0 ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rvPkg::opSystem: begin
        // only ebreak is supported
        isHalt = 1'b1;
        legal  = idInst == 32'h0010_0073;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      regWen  = 1'b0;
      storeEn = 1'b0;
      loadEn  = 1'b0;
      brOp    = rvPkg::brNone;
      isHalt  = 1'b0;
    end
    isIllegal = !legal;
  end

endmodule

// File: src/registerFile.sv
/*
  registerFile
  32 x 32-bit integer registers with x0 hard-wired to zero. A read of
  the register written in the same cycle returns the new value.
*/
`include "rv_params.svh"

module registerFile (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`RegIdWidth-1:0] rs1,
  input  logic [`RegIdWidth-1:0] rs2,
  input  logic                   wen,
  input  logic [`RegIdWidth-1:0] wrd,
  input  logic [`XLEN-1:0]       wdata,
  output logic [`XLEN-1:0]       rdata1,
  output logic [`XLEN-1:0]       rdata2
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wrd != '0) begin
      regs[wrd] <= wdata;
    end
  end

  // write-first bypass
  assign rdata1 = (rs1 == '0) ? '0 : (wen && rs1 == wrd) ? wdata : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : (wen && rs2 == wrd) ? wdata : regs[rs2];

endmodule

// File: src/executeStage.sv
/*
  executeStage
  Decode/execute register, operand forwarding from write-back, the ALU
  and branch resolution. A taken branch, a jump or an ebreak redirects
  fetch and kills the instruction entering this stage.
*/
`include "rv_params.svh"

module executeStage (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`RegIdWidth-1:0] rs1,
  input  logic [`RegIdWidth-1:0] rs2,
  input  logic [`RegIdWidth-1:0] rd,
  input  logic [`XLEN-1:0]       imm,
  input  rvPkg::aluOpT           aluOp,
  input  rvPkg::brOpT            brOp,
  input  rvPkg::memWdtT          wdt,
  input  logic                   loadEn,
  input  logic                   storeEn,
  input  logic                   unsignedLd,
  input  logic                   useImm,
  input  logic                   usePc,
  input  logic                   regWen,
  input  logic                   isHalt,
  input  logic                   isIllegal,
  input  logic [`XLEN-1:0]       opA,
  input  logic [`XLEN-1:0]       opB,
  input  logic [`XLEN-1:0]       pc,
  input  logic                   valid,
  input  logic                   wbEn,
  input  logic [`RegIdWidth-1:0] wbRd,
  input  logic [`XLEN-1:0]       wbData,
  output logic                   redirect,
  output logic [`XLEN-1:0]       redirectPc,
  output logic [`XLEN-1:0]       memAluResult,
  output logic [`XLEN-1:0]       memStoreData,
  output logic [`RegIdWidth-1:0] memRd,
  output rvPkg::memWdtT          memWdt,
  output logic                   memLoadEn,
  output logic                   memStoreEn,
  output logic                   memUnsigned,
  output logic                   memRegWen,
  output logic                   memHalt,
  output logic                   memIllegal,
  output logic [`XLEN-1:0]       memPc,
  output logic                   memValid
);

  logic [`RegIdWidth-1:0] exRs1, exRs2;
  logic [`XLEN-1:0]       exImm, exOpA, exOpB, exPc;
  rvPkg::aluOpT           exAluOp;
  rvPkg::brOpT            exBrOp;
  logic                   exValid, exUseImm, exUsePc, exHalt;
  logic [`XLEN-1:0]       fwdA, fwdB, aluA, aluB, aluOut, jalrSum;
  logic                   taken, isJump;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exValid <= 1'b0;
    end else begin
      exValid <= valid & ~redirect;
    end
  end

  always_ff @(posedge clk) begin
    exRs1       <= rs1;
    exRs2       <= rs2;
    memRd       <= rd;
    exImm       <= imm;
    exAluOp     <= aluOp;
    exBrOp      <= brOp;
    memWdt      <= wdt;
    memLoadEn   <= loadEn;
    memStoreEn  <= storeEn;
    memUnsigned <= unsignedLd;
    exUseImm    <= useImm;
    exUsePc     <= usePc;
    memRegWen   <= regWen;
    exHalt      <= isHalt;
    memIllegal  <= isIllegal;
    exOpA       <= opA;
    exOpB       <= opB;
    exPc        <= pc;
  end

  // the older instruction in memory stage wins over the register read
  assign fwdA = (wbEn && wbRd == exRs1) ? wbData : exOpA;
  assign fwdB = (wbEn && wbRd == exRs2) ? wbData : exOpB;
  assign aluA = exUsePc ? exPc : fwdA;
  assign aluB = exUseImm ? exImm : fwdB;

  always_comb begin
    case (exAluOp)
      rvPkg::aluAdd:   aluOut = aluA + aluB;
      rvPkg::aluSub:   aluOut = aluA - aluB;
      rvPkg::aluSll:   aluOut = aluA << aluB[4:0];
      rvPkg::aluSlt:   aluOut = {{(`XLEN-1){1'b0}}, $signed(aluA) < $signed(aluB)};
      rvPkg::aluSltu:  aluOut = {{(`XLEN-1){1'b0}}, aluA < aluB};
      rvPkg::aluXor:   aluOut = aluA ^ aluB;
      rvPkg::aluSrl:   aluOut = aluA >> aluB[4:0];
      rvPkg::aluSra:   aluOut = $unsigned($signed(aluA) >>> aluB[4:0]);
      rvPkg::aluOr:    aluOut = aluA | aluB;
      rvPkg::aluPassB: aluOut = aluB;
      default:         aluOut = aluA & aluB;
    endcase
  end

  always_comb begin
    case (exBrOp)
      rvPkg::brEq:   taken = fwdA == fwdB;
      rvPkg::brNe:   taken = fwdA != fwdB;
      rvPkg::brLt:   taken = $signed(fwdA) < $signed(fwdB);
      rvPkg::brGe:   taken = $signed(fwdA) >= $signed(fwdB);
      rvPkg::brLtu:  taken = fwdA < fwdB;
      rvPkg::brGeu:  taken = fwdA >= fwdB;
      rvPkg::brJal,
      rvPkg::brJalr: taken = 1'b1;
      default:       taken = 1'b0;
    endcase
  end

  assign isJump  = exBrOp == rvPkg::brJal || exBrOp == rvPkg::brJalr;
  assign jalrSum = fwdA + exImm;

  // ebreak points fetch back at itself so nothing younger slips through
  assign redirect   = exValid & (taken | exHalt);
  assign redirectPc = exHalt ? exPc :
                      (exBrOp == rvPkg::brJalr) ? {jalrSum[`XLEN-1:1], 1'b0} :
                      exPc + exImm;

  // link value for jumps
  assign memAluResult = isJump ? exPc + `XLEN'(4) : aluOut;
  assign memStoreData = fwdB;
  assign memHalt      = exHalt;
  assign memPc        = exPc;
  assign memValid     = exValid;

endmodule

// File: memory/memStage.sv
/*
  memStage
  Execute/memory register, 1 KiB data memory with byte enables, load
  extension and write-back selection. Also produces the retire and
  illegal pulses and the sticky halt level.
*/
`include "rv_params.svh"

module memStage (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`XLEN-1:0]       memAluResult,
  input  logic [`XLEN-1:0]       memStoreData,
  input  logic [`RegIdWidth-1:0] memRd,
  input  rvPkg::memWdtT          memWdt,
  input  logic                   memLoadEn,
  input  logic                   memStoreEn,
  input  logic                   memUnsigned,
  input  logic                   memRegWen,
  input  logic                   memHalt,
  input  logic                   memIllegal,
  input  logic [`XLEN-1:0]       memPc,
  input  logic                   memValid,
  output logic                   wbEn,
  output logic [`RegIdWidth-1:0] wbRd,
  output logic [`XLEN-1:0]       wbData,
  output logic                   retire,
  output logic [`XLEN-1:0]       retirePc,
  output logic                   halt,
  output logic                   illegal
);

  localparam int IdxW = $clog2(`DmemWords);

  logic [`XLEN-1:0]       dmem [`DmemWords];
  logic [`XLEN-1:0]       addrQ, storeQ, pcQ;
  logic [`RegIdWidth-1:0] rdQ;
  rvPkg::memWdtT          wdtQ;
  logic                   validQ, loadEnQ, storeEnQ, unsignedQ, regWenQ, haltQ, illegalQ;
  logic                   live;
  logic [IdxW-1:0]        wordIdx;
  logic [3:0]             byteEn;
  logic [`XLEN-1:0]       storeWord, shifted, loadVal;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validQ <= 1'b0;
      halt   <= 1'b0;
    end else begin
      validQ <= memValid;
      if (live && haltQ) begin
        halt <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    addrQ     <= memAluResult;
    storeQ    <= memStoreData;
    rdQ       <= memRd;
    wdtQ      <= memWdt;
    loadEnQ   <= memLoadEn;
    storeEnQ  <= memStoreEn;
    unsignedQ <= memUnsigned;
    regWenQ   <= memRegWen;
    haltQ     <= memHalt;
    illegalQ  <= memIllegal;
    pcQ       <= memPc;
  end

  // nothing completes after halt
  assign live    = validQ & ~halt;
  assign wordIdx = addrQ[IdxW+1:2];

  // lane placement of store data
  always_comb begin
    case (wdtQ)
      rvPkg::wdtByte: begin
        storeWord = {4{storeQ[7:0]}};
        byteEn    = 4'b0001 << addrQ[1:0];
      end
      rvPkg::wdtHalf: begin
        storeWord = {2{storeQ[15:0]}};
        byteEn    = addrQ[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        storeWord = storeQ;
        byteEn    = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (live && storeEnQ) begin
      for (int b = 0; b < 4; b++) begin
        if (byteEn[b]) begin
          dmem[wordIdx][8*b +: 8] <= storeWord[8*b +: 8];
        end
      end
    end
  end

  // addressed byte or half moved down to bit 0
  assign shifted = dmem[wordIdx] >> {addrQ[1:0], 3'b000};

  always_comb begin
    case (wdtQ)
      rvPkg::wdtByte: loadVal = {{24{~unsignedQ & shifted[7]}}, shifted[7:0]};
      rvPkg::wdtHalf: loadVal = {{16{~unsignedQ & shifted[15]}}, shifted[15:0]};
      default:        loadVal = shifted;
    endcase
  end

  assign wbEn     = live & regWenQ & (rdQ != '0);
  assign wbRd     = rdQ;
  assign wbData   = loadEnQ ? loadVal : addrQ;
  assign retire   = live;
  assign retirePc = pcQ;
  assign illegal  = live & illegalQ;

endmodule

// File: src/rvCore.sv
/*
  rvCore
  Four-stage in-order RV32I core: fetch, decode, execute and memory
  with write-back. Instructions come from an external ROM through the
  pc and inst ports.
*/
`include "rv_params.svh"

module rvCore (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`XLEN-1:0]       inst,
  output logic [`XLEN-1:0]       pc,
  output logic                   retire,
  output logic [`XLEN-1:0]       retirePc,
  output logic                   wbEn,
  output logic [`RegIdWidth-1:0] wbRd,
  output logic [`XLEN-1:0]       wbData,
  output logic                   illegal,
  output logic                   halt
);

  // fetch to decode
  logic [`XLEN-1:0]       idPc, idInst, redirectPc;
  logic                   idValid, redirect;

  // decode to execute
  logic [`RegIdWidth-1:0] rs1, rs2, rd;
  logic [`XLEN-1:0]       imm, rdata1, rdata2, opA, opB, exPc;
  rvPkg::aluOpT           aluOp;
  rvPkg::brOpT            brOp;
  rvPkg::memWdtT          idWdt;
  logic                   loadEn, storeEn, unsignedLd, useImm, usePc;
  logic                   regWen, isHalt, isIllegal, exValid;

  // execute to memory
  logic [`XLEN-1:0]       memAluResult, memStoreData, memPc;
  logic [`RegIdWidth-1:0] memRd;
  rvPkg::memWdtT          memWdt;
  logic                   memLoadEn, memStoreEn, memUnsigned, memRegWen;
  logic                   memHalt, memIllegal, memValid;

  fetchUnit u_fetchUnit (
    .clk, .arstN, .inst, .redirect, .redirectPc, .halt,
    .pc, .idPc, .idInst, .idValid
  );

  decodeUnit u_decodeUnit (
    .idInst, .idValid, .idPc, .rdata1, .rdata2,
    .rs1, .rs2, .rd, .imm, .aluOp, .brOp, .memWdt(idWdt),
    .loadEn, .storeEn, .unsignedLd, .useImm, .usePc, .regWen, .isHalt, .isIllegal,
    .opA, .opB, .exPcOut(exPc), .exValidOut(exValid)
  );

  registerFile u_registerFile (
    .clk, .arstN, .rs1, .rs2,
    .wen(wbEn), .wrd(wbRd), .wdata(wbData), .rdata1, .rdata2
  );

  executeStage u_executeStage (
    .clk, .arstN, .rs1, .rs2, .rd, .imm, .aluOp, .brOp, .wdt(idWdt),
    .loadEn, .storeEn, .unsignedLd, .useImm, .usePc, .regWen, .isHalt, .isIllegal,
    .opA, .opB, .pc(exPc), .valid(exValid), .wbEn, .wbRd, .wbData,
    .redirect, .redirectPc, .memAluResult, .memStoreData, .memRd, .memWdt,
    .memLoadEn, .memStoreEn, .memUnsigned, .memRegWen, .memHalt, .memIllegal,
    .memPc, .memValid
  );

  memStage u_memStage (
    .clk, .arstN, .memAluResult, .memStoreData, .memRd, .memWdt,
    .memLoadEn, .memStoreEn, .memUnsigned, .memRegWen, .memHalt, .memIllegal,
    .memPc, .memValid,
    .wbEn, .wbRd, .wbData, .retire, .retirePc, .halt, .illegal
  );

endmodule

// File: test/rvCore_sva.sv
/*
  rvCoreSva
  Concurrent checks on the core's retire, write-back and halt ports,
  bound into every rvCore instance.
*/
`include "rv_params.svh"

module rvCoreSva (
  input logic                   clk,
  input logic                   arstN,
  input logic [`XLEN-1:0]       pc,
  input logic                   retire,
  input logic                   wbEn,
  input logic [`RegIdWidth-1:0] wbRd,
  input logic                   illegal,
  input logic                   halt
);

  noRetireWhenHalted: assert property (@(posedge clk) disable iff (!arstN) !(retire && halt))
    else $error("retire pulsed while the core was halted");

  // x0 writes are dropped before write-back
  wbNeverToX0: assert property (@(posedge clk) disable iff (!arstN) wbEn |-> wbRd != '0)
    else $error("write-back enabled with rd equal to x0");

  // an illegal encoding retires but writes nothing
  illegalRetires: assert property (@(posedge clk) disable iff (!arstN)
                                   illegal |-> retire && !wbEn)
    else $error("illegal pulse without retire or with a write-back");

  pcFrozenOnHalt: assert property (@(posedge clk) disable iff (!arstN) halt |=> $stable(pc))
    else $error("pc moved while the core was halted");

endmodule

bind rvCore rvCoreSva u_rvCoreSva (
  .clk(clk), .arstN(arstN), .pc(pc), .retire(retire), .wbEn(wbEn),
  .wbRd(wbRd), .illegal(illegal), .halt(halt)
);

// File: test/rvCoreTb.sv
/*
  rvCoreTb
  Directed tests for the RV32I core. The testbench acts as the
  instruction ROM, keeps its own register model to predict write-backs
  and compares retire order, write-backs and illegal pulses per program.
*/
`include "rv_params.svh"

module rvCoreTb;

  localparam int Period = 4;
  localparam logic [6:0] OpImm = 7'h13;
  localparam logic [6:0] OpReg = 7'h33;
  localparam logic [6:0] OpLoad = 7'h03;
  localparam logic [6:0] OpLui = 7'h37;
  localparam logic [6:0] OpAuipc = 7'h17;
  localparam logic [6:0] OpJalr = 7'h67;
  localparam logic [31:0] Ebreak = 32'h0010_0073;
  // middle of the data memory
  localparam logic [11:0] DataBase = 12'(`DmemWords * 2);

  logic                   clk = 1'b0;
  logic                   arstN;
  logic [`XLEN-1:0]       inst, pc, retirePc, wbData;
  logic                   retire, wbEn, illegal, halt;
  logic [`RegIdWidth-1:0] wbRd;

  logic [31:0] rom [64];
  int          progLen;
  logic [31:0] x [32];
  logic [31:0] lcgState = 32'd6;
  time         limitTime = 0;
  logic [31:0] expRetPc[$], expRd[$], expData[$], expIllPc[$];
  logic [31:0] obsRetPc[$], obsRd[$], obsData[$], obsIllPc[$];

  always #(Period / 2) clk = ~clk;

  // past the program end the ROM answers ebreak
  assign inst = (int'(pc[31:2]) < progLen) ? rom[pc[7:2]] : Ebreak;

  rvCore u_rvCore (
    .clk, .arstN, .inst, .pc, .retire, .retirePc, .wbEn, .wbRd, .wbData, .illegal, .halt
  );

  always @(negedge clk) begin
    if (arstN && retire) begin
      obsRetPc.push_back(retirePc);
    end
    if (arstN && wbEn) begin
      obsRd.push_back(32'(wbRd));
      obsData.push_back(wbData);
    end
    if (arstN && illegal) begin
      obsIllPc.push_back(retirePc);
    end
  end

  // limit grows by each program's length as it is started
  always @(posedge clk) begin
    if ($time > limitTime) begin
      $display("timeout: the core never halted");
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
    end
  end

  function automatic logic [31:0] lcg();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] sext8(input logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
    end
  endtask

  task automatic newProgram();
    progLen = 0;
    foreach (x[i]) x[i] = '0;
    expRetPc.delete();
    expRd.delete();
    expData.delete();
    expIllPc.delete();
  endtask

  // live is low for slots that are killed or skipped
  task automatic emit(input logic [31:0] word, input logic live);
    if (live) begin
      expRetPc.push_back(32'(progLen * 4));
    end
    rom[progLen] = word;
    progLen++;
  endtask

  task automatic emitWb(input logic [31:0] word, input logic [4:0] rd, input logic [31:0] value);
    emit(word, 1'b1);
    if (rd != 5'd0) begin
      x[rd] = value;
      expRd.push_back(32'(rd));
      expData.push_back(value);
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    arstN <= 1'b0;
    repeat (5) @(posedge clk);
    obsRetPc.delete();
    obsRd.delete();
    obsData.delete();
    obsIllPc.delete();
    arstN <= 1'b1;
  endtask

  task automatic runProgram(input string name);
    logic [31:0] heldPc;
    limitTime += (progLen * 4 + 50) * Period;
    applyReset();
    while (!halt) @(negedge clk);
    heldPc = pc;
    // halted core stays quiet
    repeat (8) begin
      @(negedge clk);
      check({name, " retire after halt"}, 32'd0, 32'(retire));
      check({name, " halt level"}, 32'd1, 32'(halt));
      check({name, " pc after halt"}, heldPc, pc);
    end
    check({name, " retire count"}, 32'(expRetPc.size()), 32'(obsRetPc.size()));
    foreach (expRetPc[i]) check({name, " retirePc"}, expRetPc[i], obsRetPc[i]);
    check({name, " write-back count"}, 32'(expRd.size()), 32'(obsRd.size()));
    foreach (expRd[i]) check({name, " wbRd"}, expRd[i], obsRd[i]);
    foreach (expData[i]) check({name, " wbData"}, expData[i], obsData[i]);
    check({name, " illegal count"}, 32'(expIllPc.size()), 32'(obsIllPc.size()));
    foreach (expIllPc[i]) check({name, " illegal pc"}, expIllPc[i], obsIllPc[i]);
  endtask

  // every instruction depends on the one before it
  task automatic aluChainTest();
    newProgram();
    emitWb(encI(12'd5, 5'd0, 3'd0, 5'd1, OpImm), 5'd1, x[0] + 32'd5);
    emitWb(encI(12'hffd, 5'd1, 3'd0, 5'd2, OpImm), 5'd2, x[1] + sext12(12'hffd));
    emitWb(encR(7'h00, 5'd1, 5'd2, 3'd0, 5'd3, OpReg), 5'd3, x[2] + x[1]);
    emitWb(encR(7'h20, 5'd3, 5'd2, 3'd0, 5'd4, OpReg), 5'd4, x[2] - x[3]);
    emitWb(encI(12'h401, 5'd4, 3'd5, 5'd5, OpImm), 5'd5, {x[4][31], x[4][31:1]});
    emitWb(encI(12'd28, 5'd4, 3'd5, 5'd6, OpImm), 5'd6, x[4] >> 28);
    emitWb(encI(12'd4, 5'd6, 3'd1, 5'd7, OpImm), 5'd7, x[6] << 4);
    emitWb(encR(7'h00, 5'd1, 5'd4, 3'd2, 5'd8, OpReg), 5'd8,
           32'($signed(x[4]) < $signed(x[1])));
    emitWb(encR(7'h00, 5'd1, 5'd4, 3'd3, 5'd9, OpReg), 5'd9, 32'(x[4] < x[1]));
    emitWb(encI(12'h0ff, 5'd7, 3'd4, 5'd10, OpImm), 5'd10, x[7] ^ 32'h0ff);
    emitWb(encR(7'h00, 5'd5, 5'd10, 3'd6, 5'd11, OpReg), 5'd11, x[10] | x[5]);
    emitWb(encI(12'h5a5, 5'd11, 3'd7, 5'd12, OpImm), 5'd12, x[11] & 32'h5a5);
    emitWb({20'h12345, 5'd13, OpLui}, 5'd13, 32'h1234_5000);
    emitWb({20'h00001, 5'd14, OpAuipc}, 5'd14, 32'(progLen * 4) + 32'h1000);
    emitWb(encR(7'h00, 5'd2, 5'd1, 3'd1, 5'd15, OpReg), 5'd15, x[1] << x[2][4:0]);
    emit(Ebreak, 1'b1);
    runProgram("aluChain");
  endtask

  task automatic loadStoreTest();
    newProgram();
    emitWb(encI(DataBase, 5'd0, 3'd0, 5'd1, OpImm), 5'd1, 32'(DataBase));
    emitWb({20'h89abd, 5'd2, OpLui}, 5'd2, 32'h89ab_d000);
    emitWb(encI(12'hdef, 5'd2, 3'd0, 5'd2, OpImm), 5'd2, x[2] + sext12(12'hdef));
    emit(encS(12'd4, 5'd0, 5'd1, 3'd2), 1'b1);
    emit(encS(12'd0, 5'd2, 5'd1, 3'd2), 1'b1);
    emitWb(encI(12'd0, 5'd1, 3'd2, 5'd3, OpLoad), 5'd3, x[2]);
    emitWb(encI(12'd1, 5'd1, 3'd0, 5'd4, OpLoad), 5'd4, sext8(x[2][15:8]));
    emitWb(encI(12'd3, 5'd1, 3'd4, 5'd5, OpLoad), 5'd5, {24'b0, x[2][31:24]});
    emitWb(encI(12'd2, 5'd1, 3'd1, 5'd6, OpLoad), 5'd6, sext16(x[2][31:16]));
    emitWb(encI(12'd0, 5'd1, 3'd5, 5'd7, OpLoad), 5'd7, {16'b0, x[2][15:0]});
    emit(encS(12'd5, 5'd2, 5'd1, 3'd0), 1'b1);
    emit(encS(12'd6, 5'd2, 5'd1, 3'd1), 1'b1);
    // byte 5 and upper half of word 4 were overwritten
    emitWb(encI(12'd4, 5'd1, 3'd2, 5'd8, OpLoad), 5'd8, {x[2][15:0], x[2][7:0], 8'h00});
    emitWb(encR(7'h00, 5'd3, 5'd8, 3'd0, 5'd9, OpReg), 5'd9, x[8] + x[3]);
    emitWb(encI(12'd5, 5'd1, 3'd0, 5'd10, OpLoad), 5'd10, sext8(x[2][7:0]));
    emitWb(encI(12'd1, 5'd10, 3'd0, 5'd11, OpImm), 5'd11, x[10] + 32'd1);
    emit(Ebreak, 1'b1);
    runProgram("loadStore");
  endtask

  task automatic branchJumpTest();
    newProgram();
    emitWb(encI(12'd3, 5'd0, 3'd0, 5'd1, OpImm), 5'd1, 32'd3);
    emitWb(encI(12'd3, 5'd0, 3'd0, 5'd2, OpImm), 5'd2, 32'd3);
    emit(encB(13'd12, 5'd2, 5'd1, 3'd0), 1'b1);
    emit(encI(12'd1, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emit(encI(12'd2, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emit(encB(13'd8, 5'd2, 5'd1, 3'd1), 1'b1);
    emit(encB(13'd8, 5'd2, 5'd1, 3'd4), 1'b1);
    emit(encB(13'd12, 5'd2, 5'd1, 3'd7), 1'b1);
    emit(encI(12'd4, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emit(encI(12'd5, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emitWb(encJ(21'd12, 5'd5), 5'd5, 32'(progLen * 4 + 4));
    emit(encI(12'd6, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emit(encI(12'd7, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emitWb(encI(12'd68, 5'd0, 3'd0, 5'd6, OpImm), 5'd6, 32'd68);
    // odd offset, bit 0 of the target is dropped
    emitWb(encI(12'd1, 5'd6, 3'd0, 5'd7, OpJalr), 5'd7, 32'(progLen * 4 + 4));
    emit(encI(12'd8, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emit(encI(12'd9, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emit(encB(13'd8, 5'd1, 5'd0, 3'd6), 1'b1);
    emit(encI(12'd10, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emit(encB(13'd8, 5'd1, 5'd0, 3'd5), 1'b1);
    emit(Ebreak, 1'b1);
    emit(encI(12'd9, 5'd0, 3'd0, 5'd9, OpImm), 1'b0);
    runProgram("branchJump");
  endtask

  task automatic zeroRegIllegalTest();
    newProgram();
    emitWb(encI(12'd7, 5'd0, 3'd0, 5'd0, OpImm), 5'd0, 32'd7);
    emitWb(encI(12'd11, 5'd0, 3'd0, 5'd1, OpImm), 5'd1, 32'd11);
    expIllPc.push_back(32'(progLen * 4));
    emit(32'hffff_ffff, 1'b1);
    emitWb(encR(7'h00, 5'd0, 5'd1, 3'd0, 5'd2, OpReg), 5'd2, x[1] + x[0]);
    emit(Ebreak, 1'b1);
    runProgram("zeroRegIllegal");
  endtask

  task automatic randomAluTest();
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    newProgram();
    for (int i = 0; i < 20; i++) begin
      r = lcg();
      rd = {2'b00, r[18:16]} + 5'd1;
      rs1 = {2'b00, r[21:19]};
      rs2 = {2'b00, r[24:22]};
      case (r[26:25])
        2'd0: emitWb(encI(r[11:0], rs1, 3'd0, rd, OpImm), rd, x[rs1] + sext12(r[11:0]));
        2'd1: emitWb(encR(7'h00, rs2, rs1, 3'd0, rd, OpReg), rd, x[rs1] + x[rs2]);
        2'd2: emitWb(encR(7'h20, rs2, rs1, 3'd0, rd, OpReg), rd, x[rs1] - x[rs2]);
        default: emitWb(encR(7'h00, rs2, rs1, 3'd4, rd, OpReg), rd, x[rs1] ^ x[rs2]);
      endcase
    end
    emit(Ebreak, 1'b1);
    runProgram("randomAlu");
  endtask

  // code after ebreak must never complete
  task automatic haltHoldTest();
    newProgram();
    emitWb(encI(12'd1, 5'd0, 3'd0, 5'd1, OpImm), 5'd1, 32'd1);
    emit(Ebreak, 1'b1);
    emit(encI(12'd2, 5'd0, 3'd0, 5'd2, OpImm), 1'b0);
    emit(encI(12'd3, 5'd0, 3'd0, 5'd3, OpImm), 1'b0);
    emit(encS(12'd0, 5'd1, 5'd0, 3'd2), 1'b0);
    runProgram("haltHold");
  endtask

  initial begin
    arstN = 1'b0;
    aluChainTest();
    loadStoreTest();
    branchJumpTest();
    zeroRegIllegalTest();
    randomAluTest();
    haltHoldTest();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: rvCore.f
+incdir+common
common/rvPkg.sv
src/fetchUnit.sv
decode/decodeUnit.sv
src/registerFile.sv
src/executeStage.sv
memory/memStage.sv
src/rvCore.sv
test/rvCore_sva.sv
test/rvCoreTb.sv

// File: Makefile
TOP = rvCoreTb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rvCore.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
